/* sources.f */
design/uf_pkg.sv
design/uf_port_if.sv
design/neighbor_link.sv
design/processing_unit.sv
design/cluster_parity.sv
design/stage_control.sv
design/host_regs.sv
design/uf_decoder_top.sv
test/uf_protocol_checker.sv
test/tb_uf_decoder.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_uf_decoder -f sources.f
	./obj_dir/Vtb_uf_decoder > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* test/tb_uf_decoder.sv */
`timescale 1ns/1ns

module tb_uf_decoder;
    import uf_pkg::*;

    localparam int GRID_X     = 3;
    localparam int GRID_Z     = 3;
    localparam int WEIGHT_X   = 1;
    localparam int WEIGHT_Z   = 1;
    localparam int NODES      = GRID_X * GRID_Z;
    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 200;
    localparam logic [31:0] NODE_MASK = (32'd1 << NODES) - 32'd1;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [5:0]  wb_adr;
    logic [31:0] wb_wdat;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    logic        run_passed;
    logic        fail_printed;

    // software model state
    logic [31:0] m_syn;
    int          m_root [NODES];
    logic        m_odd  [NODES];
    int          m_bcnt [NODES];
    int          m_vcnt [NODES];
    int          m_hcnt [NODES];

    logic [31:0] got_odd;
    logic [31:0] got_touch;
    logic [31:0] got_root [NODES];

    uf_decoder_top #(
        .GRID_X   (GRID_X),
        .GRID_Z   (GRID_Z),
        .WEIGHT_X (WEIGHT_X),
        .WEIGHT_Z (WEIGHT_Z)
    ) uf_decoder_top_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_wdat),
        .wb_dat_o (wb_rdat),
        .wb_ack_o (wb_ack)
    );

    bind uf_decoder_top uf_protocol_checker uf_protocol_checker_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_ack_i (wb_ack_o),
        .stage_i  (stage),
        .busy_i   (busy),
        .done_i   (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        fail_printed = 1'b1;
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic bus_cycle(input logic we, input logic [5:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc  <= 1'b1;
        wb_stb  <= 1'b1;
        wb_we   <= we;
        wb_adr  <= adr;
        wb_wdat <= wdata;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) stop_with_error("no Wishbone ack arrived in time");
        end while (!wb_ack);
        rdata = wb_rdat;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        assert (!wb_ack) else
            stop_with_error($sformatf("FAIL %0t ns: ack held for a second cycle", $time));
    endtask

    task automatic bus_write(input logic [5:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [5:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'd0, data);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int polls;
        polls = 0;
        do begin
            bus_read(reg_status, status);
            polls++;
            if (polls > POLL_LIMIT) stop_with_error("decoder never reported done");
        end while (!status[1]);
        assert (!status[0]) else
            stop_with_error($sformatf("FAIL %0t ns: busy set together with done", $time));
    endtask

    // per-root parity and boundary contact decide which nodes stay odd
    function automatic logic update_odd();
        logic [NODES-1:0] par;
        logic [NODES-1:0] hit;
        logic any;
        par = '0;
        hit = '0;
        any = 1'b0;
        for (int n = 0; n < NODES; n++) begin
            par[m_root[n]] = par[m_root[n]] ^ m_syn[n];
            hit[m_root[n]] = hit[m_root[n]] | (m_bcnt[n] == 2 * WEIGHT_Z);
        end
        for (int n = 0; n < NODES; n++) begin
            m_odd[n] = par[m_root[n]] && !hit[m_root[n]];
            any = any | m_odd[n];
        end
        return any;
    endfunction

    function automatic int capped(input int value, input int cap);
        return (value > cap) ? cap : value;
    endfunction

    function automatic void grow_clusters();
        for (int n = 0; n < NODES; n++) begin
            if (n / GRID_Z < GRID_X - 1) begin
                m_vcnt[n] = capped(m_vcnt[n] + int'(m_odd[n]) + int'(m_odd[n + GRID_Z]),
                                   2 * WEIGHT_X);
            end
            if (n % GRID_Z < GRID_Z - 1) begin
                m_hcnt[n] = capped(m_hcnt[n] + int'(m_odd[n]) + int'(m_odd[n + 1]),
                                   2 * WEIGHT_Z);
            end
            if ((n % GRID_Z == 0 || n % GRID_Z == GRID_Z - 1) && m_odd[n]) begin
                m_bcnt[n] = capped(m_bcnt[n] + 1, 2 * WEIGHT_Z);
            end
        end
    endfunction

    function automatic logic join_ends(input int a, input int b);
        int low;
        low = (m_root[a] < m_root[b]) ? m_root[a] : m_root[b];
        join_ends = (m_root[a] != low) || (m_root[b] != low);
        m_root[a] = low;
        m_root[b] = low;
    endfunction

    // components over grown edges, labelled by their lowest address
    function automatic void merge_clusters();
        logic moved;
        do begin
            moved = 1'b0;
            for (int n = 0; n < NODES; n++) begin
                if (n / GRID_Z < GRID_X - 1 && m_vcnt[n] == 2 * WEIGHT_X)
                    moved = join_ends(n, n + GRID_Z) | moved;
                if (n % GRID_Z < GRID_Z - 1 && m_hcnt[n] == 2 * WEIGHT_Z)
                    moved = join_ends(n, n + 1) | moved;
            end
        end while (moved);
    endfunction

    function automatic void run_model(input logic [31:0] syn);
        m_syn = syn;
        for (int n = 0; n < NODES; n++) begin
            m_root[n] = n;
            m_bcnt[n] = 0;
            m_vcnt[n] = 0;
            m_hcnt[n] = 0;
        end
        void'(update_odd());
        do begin
            grow_clusters();
            merge_clusters();
        end while (update_odd());
    endfunction

    task automatic decode_and_check(input logic [31:0] syn);
        logic [31:0] data;
        logic [31:0] exp_touch;
        run_model(syn);
        exp_touch = '0;
        for (int n = 0; n < NODES; n++) begin
            exp_touch[n] = (m_bcnt[n] == 2 * WEIGHT_Z);
        end
        bus_write(reg_syndrome, syn);
        bus_read(reg_syndrome, data);
        assert (data == syn) else
            stop_with_error($sformatf("FAIL %0t ns: syndrome reads %h, wrote %h",
                                      $time, data, syn));
        bus_write(reg_ctrl, 32'd1);
        wait_done();
        bus_read(reg_odd, got_odd);
        assert (got_odd == 32'd0) else
            stop_with_error($sformatf("FAIL %0t ns: odd mask %h at done", $time, got_odd));
        bus_read(reg_touch, got_touch);
        assert (got_touch == exp_touch) else
            stop_with_error($sformatf("FAIL %0t ns: touch mask %h, expected %h",
                                      $time, got_touch, exp_touch));
        for (int n = 0; n < NODES; n++) begin
            bus_read(6'(int'(reg_root_base) + n), got_root[n]);
            assert (got_root[n] == 32'(m_root[n])) else
                stop_with_error($sformatf("FAIL %0t ns: node %0d root %0d, expected %0d",
                                          $time, n, got_root[n], m_root[n]));
        end
    endtask

    initial begin
        logic [31:0] syn;
        logic [31:0] data;
        void'($urandom(77531));
        run_passed   = 1'b0;
        fail_printed = 1'b0;
        reset   = 1'b1;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_adr  = '0;
        wb_wdat = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // a syndrome write during decoding must not land
        syn = 32'h0000_0111 & NODE_MASK;
        decode_and_check(syn);
        bus_write(reg_ctrl, 32'd1);
        bus_write(reg_syndrome, ~syn & NODE_MASK);
        wait_done();
        bus_read(reg_syndrome, data);
        assert (data == syn) else
            stop_with_error($sformatf("FAIL %0t ns: busy write changed syndrome to %h",
                                      $time, data));

        decode_and_check(32'd0);
        for (int n = 0; n < NODES; n++) begin
            assert (got_root[n] == 32'(n) && got_touch == 32'd0) else
                stop_with_error($sformatf("FAIL %0t ns: empty syndrome left node %0d at root %0d",
                                          $time, n, got_root[n]));
        end

        // single defect on the left boundary, then a pair across the middle row
        decode_and_check(32'h0000_0008);
        assert (got_touch[3]) else
            stop_with_error($sformatf("FAIL %0t ns: edge defect did not touch", $time));
        decode_and_check(32'h0000_0028);
        assert (got_root[3] == got_root[5] && got_root[5] <= 32'd3) else
            stop_with_error($sformatf("FAIL %0t ns: pair roots %0d and %0d",
                                      $time, got_root[3], got_root[5]));

        repeat (20) begin
            syn = $urandom & NODE_MASK;
            decode_and_check(syn);
        end

        run_passed = 1'b1;
        $display("TEST OK");
        $finish;
    end

    final begin
        if (!run_passed && !fail_printed) begin
            $display("TEST FAILED");
        end
    end

endmodule

/* test/uf_protocol_checker.sv */
`timescale 1ns/1ns

module uf_protocol_checker (
    input logic           clk,
    input logic           reset,
    input logic           wb_cyc_i,
    input logic           wb_stb_i,
    input logic           wb_ack_i,
    input uf_pkg::stage_e stage_i,
    input logic           busy_i,
    input logic           done_i
);
    import uf_pkg::*;

    // ack answers a request seen on the previous edge
    ack_after_request: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i)
    ) else $error("ack without a preceding cyc and stb");

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack_i |=> !wb_ack_i
    ) else $error("ack high for two cycles in a row");

    stage_legal: assert property (
        @(posedge clk) disable iff (reset)
        stage_i inside {stage_idle, stage_load, stage_grow,
                        stage_merge, stage_check, stage_done}
    ) else $error("stage holds an illegal encoding");

    // done and busy are exclusive
    done_not_busy: assert property (
        @(posedge clk) disable iff (reset)
        !(done_i && busy_i)
    ) else $error("done and busy high together");

endmodule

/* design/uf_decoder_top.sv */
`timescale 1ns/1ns

module uf_decoder_top #(
    parameter int GRID_X   = 3,
    parameter int GRID_Z   = 3,
    parameter int WEIGHT_X = 1,
    parameter int WEIGHT_Z = 1
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [5:0]                   wb_adr_i,
    input  logic [uf_pkg::WB_DATA_W-1:0] wb_dat_i,
    output logic [uf_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic                         wb_ack_o
);
    import uf_pkg::*;

    localparam int NODES = GRID_X * GRID_Z;

    stage_e               stage;
    logic                 start;
    logic                 busy;
    logic                 done;
    logic                 any_odd;
    logic                 merge_active;
    logic [MAX_NODES-1:0] syndrome;
    logic [MAX_NODES-1:0] unit_syndrome;
    logic [MAX_NODES-1:0] odd;
    logic [MAX_NODES-1:0] touch;
    logic [MAX_NODES-1:0] changed;
    node_addr_t           roots [MAX_NODES];

    uf_port_if north_if [NODES] ();
    uf_port_if south_if [NODES] ();
    uf_port_if west_if  [NODES] ();
    uf_port_if east_if  [NODES] ();

    host_regs u_host_regs (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .syndrome_o (syndrome),
        .start_o    (start),
        .busy_i     (busy),
        .done_i     (done),
        .odd_i      (odd),
        .touch_i    (touch),
        .roots_i    (roots)
    );

    stage_control u_stage_control (
        .clk            (clk),
        .reset          (reset),
        .start_i        (start),
        .merge_active_i (merge_active),
        .any_odd_i      (any_odd),
        .stage_o        (stage),
        .busy_o         (busy),
        .done_o         (done)
    );

    cluster_parity #(
        .GRID_X (GRID_X),
        .GRID_Z (GRID_Z)
    ) u_cluster_parity (
        .roots_i    (roots),
        .syndrome_i (unit_syndrome),
        .touch_i    (touch),
        .odd_o      (odd),
        .any_odd_o  (any_odd)
    );

    assign merge_active = |changed;

    for (genvar n = 0; n < MAX_NODES; n++) begin : g_node
        if (n < NODES) begin : g_unit
            processing_unit #(
                .I        (n / GRID_Z),
                .J        (n % GRID_Z),
                .GRID_X   (GRID_X),
                .GRID_Z   (GRID_Z),
                .WEIGHT_Z (WEIGHT_Z)
            ) u_unit (
                .clk        (clk),
                .reset      (reset),
                .stage_i    (stage),
                .syndrome_i (syndrome[n]),
                .is_odd_i   (odd[n]),
                .root_o     (roots[n]),
                .syndrome_o (unit_syndrome[n]),
                .touch_o    (touch[n]),
                .changed_o  (changed[n]),
                .north      (north_if[n]),
                .south      (south_if[n]),
                .west       (west_if[n]),
                .east       (east_if[n])
            );

            // edge to the unit below
            if (n / GRID_Z < GRID_X - 1) begin : g_vlink
                neighbor_link #(
                    .LENGTH (2 * WEIGHT_X)
                ) u_vlink (
                    .clk     (clk),
                    .reset   (reset),
                    .stage_i (stage),
                    .end_a   (south_if[n]),
                    .end_b   (north_if[n + GRID_Z])
                );
            end

            // edge to the unit on the right
            if (n % GRID_Z < GRID_Z - 1) begin : g_hlink
                neighbor_link #(
                    .LENGTH (2 * WEIGHT_Z)
                ) u_hlink (
                    .clk     (clk),
                    .reset   (reset),
                    .stage_i (stage),
                    .end_a   (east_if[n]),
                    .end_b   (west_if[n + 1])
                );
            end
        end else begin : g_pad
            assign roots[n]         = '0;
            assign unit_syndrome[n] = 1'b0;
            assign touch[n]         = 1'b0;
            assign changed[n]       = 1'b0;
        end
    end

endmodule

/* design/host_regs.sv */
`timescale 1ns/1ns

module host_regs (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [5:0]                      wb_adr_i,
    input  logic [uf_pkg::WB_DATA_W-1:0]    wb_dat_i,
    output logic [uf_pkg::WB_DATA_W-1:0]    wb_dat_o,
    output logic                            wb_ack_o,
    output logic [uf_pkg::MAX_NODES-1:0]    syndrome_o,
    output logic                            start_o,
    input  logic                            busy_i,
    input  logic                            done_i,
    input  logic [uf_pkg::MAX_NODES-1:0]    odd_i,
    input  logic [uf_pkg::MAX_NODES-1:0]    touch_i,
    input  uf_pkg::node_addr_t              roots_i [uf_pkg::MAX_NODES]
);
    import uf_pkg::*;

    logic                 access;
    logic                 wr_en;
    reg_addr_e            addr;
    logic [5:0]           root_idx;
    logic [WB_DATA_W-1:0] rd_data;

    // no back-to-back access while ack is high
    assign access   = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_en    = access && wb_we_i && !busy_i;
    assign addr     = reg_addr_e'(wb_adr_i);
    assign root_idx = wb_adr_i - reg_root_base;

    always_comb begin
        rd_data = '0;
        case (addr)
            reg_status:   rd_data = WB_DATA_W'({done_i, busy_i});
            reg_syndrome: rd_data = syndrome_o;
            reg_odd:      rd_data = odd_i;
            reg_touch:    rd_data = touch_i;
            default: begin
                if (wb_adr_i >= reg_root_base && root_idx < MAX_NODES) begin
                    rd_data = WB_DATA_W'(roots_i[root_idx[4:0]]);
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack_o   <= 1'b0;
            start_o    <= 1'b0;
            syndrome_o <= '0;
        end else begin
            wb_ack_o <= access;
            start_o  <= wr_en && addr == reg_ctrl && wb_dat_i[0];
            if (wr_en && addr == reg_syndrome) begin
                syndrome_o <= wb_dat_i;
            end
        end
    end

    // read data valid with ack
    always_ff @(posedge clk) begin
        if (access) wb_dat_o <= rd_data;
    end

endmodule

/* design/stage_control.sv */
`timescale 1ns/1ns

module stage_control (
    input  logic           clk,
    input  logic           reset,
    input  logic           start_i,
    input  logic           merge_active_i,
    input  logic           any_odd_i,
    output uf_pkg::stage_e stage_o,
    output logic           busy_o,
    output logic           done_o
);
    import uf_pkg::*;

    stage_e     state;
    logic [1:0] settle;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= stage_idle;
            settle <= '0;
        end else begin
            case (state)
                stage_idle, stage_done: begin
                    if (start_i) state <= stage_load;
                end
                stage_load: state <= stage_grow;
                stage_grow: begin
                    state  <= stage_merge;
                    settle <= '0;
                end
                stage_merge: begin
                    // link flags lag the grow step by one cycle
                    // and change flags lag the roots by one more
                    if (settle != 2'd2) begin
                        settle <= settle + 2'd1;
                    end else if (!merge_active_i) begin
                        state <= stage_check;
                    end
                end
                stage_check: state <= any_odd_i ? stage_grow : stage_done;
                default: state <= stage_idle;
            endcase
        end
    end

    assign stage_o = state;
    assign busy_o  = (state == stage_load) || (state == stage_grow) ||
                     (state == stage_merge) || (state == stage_check);
    assign done_o  = (state == stage_done);

endmodule

/* design/cluster_parity.sv */
`timescale 1ns/1ns

module cluster_parity #(
    parameter int GRID_X = 3,
    parameter int GRID_Z = 3
) (
    input  uf_pkg::node_addr_t                roots_i [uf_pkg::MAX_NODES],
    input  logic [uf_pkg::MAX_NODES-1:0]      syndrome_i,
    input  logic [uf_pkg::MAX_NODES-1:0]      touch_i,
    output logic [uf_pkg::MAX_NODES-1:0]      odd_o,
    output logic                              any_odd_o
);
    import uf_pkg::*;

    localparam int NODES = GRID_X * GRID_Z;

    // indexed by root address
    logic [MAX_NODES-1:0] parity;
    logic [MAX_NODES-1:0] touched;

    always_comb begin
        parity  = '0;
        touched = '0;
        odd_o   = '0;
        for (int n = 0; n < NODES; n++) begin
            parity[roots_i[n]]  = parity[roots_i[n]] ^ syndrome_i[n];
            touched[roots_i[n]] = touched[roots_i[n]] | touch_i[n];
        end
        // a cluster stays odd until it reaches a boundary
        for (int n = 0; n < NODES; n++) begin
            odd_o[n] = parity[roots_i[n]] & ~touched[roots_i[n]];
        end
    end

    assign any_odd_o = |odd_o;

endmodule

/* design/processing_unit.sv */
`timescale 1ns/1ns

module processing_unit #(
    parameter int I        = 0,
    parameter int J        = 0,
    parameter int GRID_X   = 3,
    parameter int GRID_Z   = 3,
    parameter int WEIGHT_Z = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  uf_pkg::stage_e     stage_i,
    input  logic               syndrome_i,
    input  logic               is_odd_i,
    output uf_pkg::node_addr_t root_o,
    output logic               syndrome_o,
    output logic               touch_o,
    output logic               changed_o,
    uf_port_if.unit            north,
    uf_port_if.unit            south,
    uf_port_if.unit            west,
    uf_port_if.unit            east
);
    import uf_pkg::*;

    localparam node_addr_t MY_ADDR = node_addr_t'(I * GRID_Z + J);
    localparam int BOUNDARY_COST = 2 * WEIGHT_Z;
    localparam int BCNT_W = $clog2(BOUNDARY_COST + 1);

    node_addr_t root;
    node_addr_t best;
    node_addr_t cand_n;
    node_addr_t cand_s;
    node_addr_t cand_w;
    node_addr_t cand_e;
    logic       syndrome;
    logic       changed;

    assign north.own_root = root;
    assign south.own_root = root;
    assign west.own_root  = root;
    assign east.own_root  = root;
    assign north.increase = is_odd_i;
    assign south.increase = is_odd_i;
    assign west.increase  = is_odd_i;
    assign east.increase  = is_odd_i;

    // missing neighbors fall back to own root
    if (I > 0) begin : g_north
        assign cand_n = north.fully_grown ? north.neighbor_root : root;
    end else begin : g_no_north
        assign cand_n = root;
    end

    if (I < GRID_X - 1) begin : g_south
        assign cand_s = south.fully_grown ? south.neighbor_root : root;
    end else begin : g_no_south
        assign cand_s = root;
    end

    if (J > 0) begin : g_west
        assign cand_w = west.fully_grown ? west.neighbor_root : root;
    end else begin : g_no_west
        assign cand_w = root;
    end

    if (J < GRID_Z - 1) begin : g_east
        assign cand_e = east.fully_grown ? east.neighbor_root : root;
    end else begin : g_no_east
        assign cand_e = root;
    end

    always_comb begin
        best = root;
        if (cand_n < best) best = cand_n;
        if (cand_s < best) best = cand_s;
        if (cand_w < best) best = cand_w;
        if (cand_e < best) best = cand_e;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            root     <= MY_ADDR;
            syndrome <= 1'b0;
            changed  <= 1'b0;
        end else if (stage_i == stage_load) begin
            root     <= MY_ADDR;
            syndrome <= syndrome_i;
            changed  <= 1'b0;
        end else if (stage_i == stage_merge) begin
            root    <= best;
            changed <= (best != root);
        end else begin
            changed <= 1'b0;
        end
    end

    // first and last column see the boundary
    if (J == 0 || J == GRID_Z - 1) begin : g_boundary
        logic [BCNT_W-1:0] bcount;

        always_ff @(posedge clk) begin
            if (reset || stage_i == stage_load) begin
                bcount <= '0;
            end else if (stage_i == stage_grow && is_odd_i &&
                         bcount != BCNT_W'(BOUNDARY_COST)) begin
                bcount <= bcount + 1'b1;
            end
        end

        assign touch_o = (bcount == BCNT_W'(BOUNDARY_COST));
    end else begin : g_interior
        assign touch_o = 1'b0;
    end

    assign root_o     = root;
    assign syndrome_o = syndrome;
    assign changed_o  = changed;

endmodule

/* design/neighbor_link.sv */
`timescale 1ns/1ns

module neighbor_link #(
    parameter int LENGTH = 2
) (
    input  logic           clk,
    input  logic           reset,
    input  uf_pkg::stage_e stage_i,
    uf_port_if.link        end_a,
    uf_port_if.link        end_b
);
    import uf_pkg::*;

    localparam int CNT_W = $clog2(LENGTH + 1);

    logic [CNT_W-1:0] count;
    logic [CNT_W:0]   sum;
    logic [1:0]       inc;
    logic             grown;

    // each odd endpoint adds one unit of growth
    assign inc = {1'b0, end_a.increase} + {1'b0, end_b.increase};
    assign sum = {1'b0, count} + (CNT_W + 1)'(inc);

    always_ff @(posedge clk) begin
        if (reset || stage_i == stage_load) begin
            count <= '0;
            grown <= 1'b0;
        end else begin
            if (stage_i == stage_grow) begin
                count <= (sum >= (CNT_W + 1)'(LENGTH)) ? CNT_W'(LENGTH) : sum[CNT_W-1:0];
            end
            grown <= (count == CNT_W'(LENGTH));
        end
    end

    // roots only cross once the edge is grown
    assign end_a.neighbor_root = grown ? end_b.own_root : end_a.own_root;
    assign end_b.neighbor_root = grown ? end_a.own_root : end_b.own_root;
    assign end_a.fully_grown   = grown;
    assign end_b.fully_grown   = grown;

endmodule

/* design/uf_port_if.sv */
`timescale 1ns/1ns

// one side of an edge as seen by a processing unit
interface uf_port_if;
    import uf_pkg::*;

    node_addr_t own_root;
    logic       increase;
    node_addr_t neighbor_root;
    logic       fully_grown;

    modport unit (
        output own_root,
        output increase,
        input  neighbor_root,
        input  fully_grown
    );

    modport link (
        input  own_root,
        input  increase,
        output neighbor_root,
        output fully_grown
    );

endinterface

/* design/uf_pkg.sv */
package uf_pkg;

    // 32-bit host data word bounds the grid size
    localparam int MAX_NODES = 32;
    localparam int WB_DATA_W = 32;

    // row * GRID_Z + column
    typedef logic [4:0] node_addr_t;

    typedef enum logic [2:0] {
        stage_idle,
        stage_load,
        stage_grow,
        stage_merge,
        stage_check,
        stage_done
    } stage_e;

    // host word addresses, node n root at reg_root_base + n
    typedef enum logic [5:0] {
        reg_ctrl      = 6'd0,
        reg_status    = 6'd1,
        reg_syndrome  = 6'd2,
        reg_odd       = 6'd3,
        reg_touch     = 6'd4,
        reg_root_base = 6'd8
    } reg_addr_e;

endpackage
